// ==== sim.f ====
logic/rv_pkg.sv
logic/decoder.sv
logic/exec_unit.sv
logic/fetch_unit.sv
logic/lsu.sv
logic/mem_arbiter.sv
logic/unified_ram.sv
logic/rv_core_top.sv
verification/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/decoder.sv
  - logic/exec_unit.sv
  - logic/fetch_unit.sv
  - logic/lsu.sv
  - logic/mem_arbiter.sv
  - logic/unified_ram.sv
  - logic/rv_core_top.sv
  - target: test
    files:
      - verification/tb_rv_core.sv

// ==== verification/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;
  import rv_pkg::*;

  localparam int num_progs = 4;
  localparam int prog_words = 256;
  localparam int setup_len = 22;
  localparam int body_end = 112;
  localparam int cycle_limit = num_progs * (20 * body_end + mem_words + 16);

  logic clk, rst_n, run, prog_we;
  logic [mem_addr_w-1:0] prog_addr;
  logic [xlen-1:0] prog_wdata;
  logic retire_valid, retire_we;
  logic [xlen-1:0] retire_pc, retire_data;
  logic [4:0] retire_rd;

  logic [31:0] image [mem_words];
  logic [31:0] model_mem [mem_words];
  logic [31:0] model_regs [32];
  logic jump_tgt [prog_words];
  logic [31:0] exp_pc [$];
  logic [31:0] exp_data [$];
  logic [4:0] exp_rd [$];
  logic exp_we [$];
  logic [31:0] pc_e, data_e;
  logic [4:0] rd_e;
  logic we_e;
  logic first_retire, prog_done;
  int errors = 0;
  int cycles = 0;

  rv_core_top UUT (
    .clk, .rst_n, .run, .prog_we, .prog_addr, .prog_wdata,
    .retire_valid, .retire_pc, .retire_rd, .retire_data, .retire_we
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // x8..x15 hold data, x0 now and then.
  function automatic logic [4:0] data_reg();
    int r;
    r = $urandom % 9;
    return (r == 8) ? 5'd0 : 5'(8 + r);
  endfunction

  function automatic logic [4:0] base_reg();
    return 5'(1 + $urandom % 7);
  endfunction

  function automatic logic [11:0] mem_offset(input logic [1:0] size_log2);
    logic [11:0] off;
    off = 12'($urandom % 128) - 12'd64;
    return off & ~((12'd1 << size_log2) - 12'd1); // Aligned to the access size.
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
      input logic [31:0] x, input logic [31:0] y);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? x - y : x + y;
      3'd1: r = x << y[4:0];
      3'd2: r = {31'd0, $signed(x) < $signed(y)};
      3'd3: r = {31'd0, x < y};
      3'd4: r = x ^ y;
      3'd5: begin
        if (alt) r = $signed(x) >>> y[4:0];
        else r = x >> y[4:0];
      end
      3'd6: r = x | y;
      default: r = x & y;
    endcase
    return r;
  endfunction

  task automatic build_program();
    int p, k, sel, jimm;
    logic [2:0] f3;
    logic [6:0] f7;
    for (int w = 0; w < mem_words; w++) begin
      image[w] = $urandom ^ (w * 32'h9e3779b9);
    end
    for (int w = 0; w < prog_words; w++) begin
      jump_tgt[w] = 1'b0;
    end
    for (int i = 1; i < 8; i++) begin
      image[2*i-2] = i_type(12'd1024, 5'd0, 3'd0, 5'(i), op_imm);
      image[2*i-1] = i_type(12'(960 + 128 * i), 5'(i), 3'd0, 5'(i), op_imm); // Data base.
    end
    for (int j = 0; j < 8; j++) begin
      image[14+j] = i_type(12'($urandom), 5'd0, 3'd0, 5'(8 + j), op_imm);
    end
    p = setup_len;
    while (p < body_end) begin
      sel = $urandom % 17;
      f3 = 3'($urandom % 8);
      k = 1 + $urandom % 4;
      if (sel < 4) begin
        if (f3 == 3'd1) image[p] = i_type(12'($urandom % 32), data_reg(), f3, data_reg(), op_imm);
        else if (f3 == 3'd5)
          image[p] = i_type({1'b0, 1'($urandom % 2), 5'd0, 5'($urandom % 32)},
                            data_reg(), f3, data_reg(), op_imm);
        else image[p] = i_type(12'($urandom), data_reg(), f3, data_reg(), op_imm);
      end else if (sel < 7) begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2)) ? 7'b0100000 : 7'd0;
        image[p] = r_type(f7, data_reg(), data_reg(), f3, data_reg(), op_reg);
      end else if (sel < 9) begin
        f3 = 3'($urandom % 5);
        if (f3 > 3'd2) f3 = f3 + 3'd1; // LBU and LHU.
        image[p] = i_type(mem_offset(f3[1:0]), base_reg(), f3, data_reg(), op_load);
      end else if (sel < 11) begin
        f3 = 3'($urandom % 3);
        image[p] = s_type(mem_offset(f3[1:0]), data_reg(), base_reg(), f3);
      end else if (sel == 11) begin
        f7 = ($urandom % 2) ? 7'b0000100 : 7'b0000000; // Swap or add.
        image[p] = r_type(f7, data_reg(), base_reg(), 3'd2, data_reg(), op_atomic);
      end else if (sel < 14) begin
        f3 = 3'($urandom % 6);
        if (f3 > 3'd1) f3 = f3 + 3'd2;
        image[p] = b_type(13'(4 * k), data_reg(), data_reg(), f3);
        jump_tgt[p+k] = 1'b1;
      end else if (sel == 14) begin
        image[p] = j_type(21'(4 * k), data_reg());
        jump_tgt[p+k] = 1'b1;
      end else if (sel == 15 && p + 1 < body_end && !jump_tgt[p+1]) begin
        // Pair of ADDI x17 and JALR, nothing may land between them.
        jimm = int'($urandom % 32) - 16;
        image[p] = i_type(12'(4 * (p + 1 + k) - jimm + int'($urandom % 2)),
                          5'd0, 3'd0, 5'd17, op_imm);
        image[p+1] = i_type(12'(jimm), 5'd17, 3'd0, data_reg(), op_jalr);
        jump_tgt[p+1+k] = 1'b1;
        p = p + 1;
      end else begin
        image[p] = {20'($urandom), data_reg(), 7'b0110111}; // LUI, unsupported.
      end
      p = p + 1;
    end
    for (int w = body_end; w < prog_words; w++) begin
      image[w] = j_type(21'd0, 5'd0);
    end
  endtask

  task automatic run_model();
    logic [31:0] pc, ins, a, b, imm_i, imm_s, imm_b, imm_j, val, addr, word, nxt;
    logic we, taken, done;
    int steps;
    for (int w = 0; w < mem_words; w++) begin
      model_mem[w] = image[w];
    end
    pc = reset_pc;
    steps = 0;
    done = 1'b0;
    while (!done) begin
      ins = model_mem[pc[11:2]];
      a = (ins[19:15] == 5'd0) ? 32'd0 : model_regs[ins[19:15]];
      b = (ins[24:20] == 5'd0) ? 32'd0 : model_regs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      nxt = pc + 32'd4;
      we = 1'b0;
      val = 32'd0;
      case (ins[6:0])
        op_imm: begin
          we = 1'b1;
          val = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
        end
        op_reg: begin
          we = 1'b1;
          val = alu_ref(ins[14:12], ins[30], a, b);
        end
        op_load: begin
          addr = a + imm_i;
          word = model_mem[addr[11:2]] >> (8 * addr[1:0]);
          case (ins[14:12])
            3'd0: val = {{24{word[7]}}, word[7:0]};
            3'd1: val = {{16{word[15]}}, word[15:0]};
            3'd4: val = {24'd0, word[7:0]};
            3'd5: val = {16'd0, word[15:0]};
            default: val = word;
          endcase
          we = 1'b1;
        end
        op_store: begin
          addr = a + imm_s;
          word = model_mem[addr[11:2]];
          for (int i = 0; i < (1 << ins[13:12]); i++) begin
            word[8*(addr[1:0] + i) +: 8] = b[8*i +: 8];
          end
          model_mem[addr[11:2]] = word;
        end
        op_atomic: begin
          word = model_mem[a[11:2]];
          model_mem[a[11:2]] = (ins[31:27] == 5'b00001) ? b : word + b;
          val = word; // Old word goes to rd.
          we = 1'b1;
        end
        op_branch: begin
          case (ins[14:12])
            3'd0: taken = (a == b);
            3'd1: taken = (a != b);
            3'd4: taken = $signed(a) < $signed(b);
            3'd5: taken = $signed(a) >= $signed(b);
            3'd6: taken = a < b;
            default: taken = a >= b;
          endcase
          if (taken) nxt = pc + imm_b;
        end
        op_jal: begin
          we = 1'b1;
          val = pc + 32'd4;
          nxt = pc + imm_j;
        end
        op_jalr: begin
          we = 1'b1;
          val = pc + 32'd4;
          nxt = (a + imm_i) & ~32'd1;
        end
        default: ;
      endcase
      exp_pc.push_back(pc);
      exp_rd.push_back(ins[11:7]);
      exp_data.push_back(val);
      exp_we.push_back(we);
      if (we && ins[11:7] != 5'd0) model_regs[ins[11:7]] = val;
      pc = nxt;
      steps++;
      done = (ins == j_type(21'd0, 5'd0)) || (steps > 400); // Final self loop.
    end
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expected,
      input logic [31:0] actual);
    errors++;
    $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, what, expected, actual);
  endtask

  always @(negedge clk) begin
    if (rst_n && retire_valid) begin
      if (!run) begin
        errors++;
        $display("Retire seen at %0t ns while run is low", $time);
      end
      if (exp_pc.size() == 0) begin
        errors++;
        $display("Retire at %0t ns with pc %h after the model ran out of entries",
                 $time, retire_pc);
      end else begin
        pc_e = exp_pc.pop_front();
        rd_e = exp_rd.pop_front();
        data_e = exp_data.pop_front();
        we_e = exp_we.pop_front();
        if (first_retire && retire_pc != reset_pc) report_mismatch("first pc", reset_pc, retire_pc);
        if (retire_pc !== pc_e) report_mismatch("retire_pc", pc_e, retire_pc);
        if (retire_we !== we_e) report_mismatch("retire_we", 32'(we_e), 32'(retire_we));
        if (we_e && retire_rd !== rd_e) report_mismatch("retire_rd", 32'(rd_e), 32'(retire_rd));
        if (we_e && retire_data !== data_e) report_mismatch("retire_data", data_e, retire_data);
        first_retire = 1'b0;
        if (exp_pc.size() == 0) prog_done = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the programs did not finish", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    rst_n = 1'b0;
    run = 1'b0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_wdata = '0;
    first_retire = 1'b0;
    prog_done = 1'b0;
    void'($urandom(32'hbc3df9e5));
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    for (int n = 0; n < num_progs; n++) begin
      build_program();
      run_model();
      for (int w = 0; w < mem_words; w++) begin
        @(posedge clk);
        prog_we <= 1'b1;
        prog_addr <= w[mem_addr_w-1:0];
        prog_wdata <= image[w];
      end
      @(posedge clk);
      prog_we <= 1'b0;
      repeat (4) @(posedge clk);
      first_retire = 1'b1;
      prog_done = 1'b0;
      run <= 1'b1;
      while (!prog_done) @(posedge clk);
      run <= 1'b0; // Stop right after the final retire.
      repeat (6) @(posedge clk);
    end
    $display("Run finished with %0d errors over %0d programs", errors, num_progs);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== logic/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  input  logic prog_we,
  input  logic [rv_pkg::mem_addr_w-1:0] prog_addr,
  input  logic [rv_pkg::xlen-1:0] prog_wdata,
  output logic retire_valid,
  output logic [rv_pkg::xlen-1:0] retire_pc,
  output logic [4:0] retire_rd,
  output logic [rv_pkg::xlen-1:0] retire_data,
  output logic retire_we
);
  import rv_pkg::*;

  logic fetch_start, pc_load, fetch_req, fetch_gnt, fetch_done;
  logic [xlen-1:0] next_pc, pc, instr;
  logic [mem_addr_w-1:0] fetch_addr, lsu_addr, ram_addr;
  logic mem_start, mem_read, mem_write, mem_done;
  logic [xlen-1:0] mem_addr, mem_wdata, load_data;
  mem_len_e mem_len;
  atomic_e atomic_op;
  logic lsu_req, lsu_we, lsu_gnt, ram_en, ram_we;
  logic [3:0] lsu_be, ram_be;
  logic [xlen-1:0] lsu_wdata, ram_wdata, ram_rdata;

  exec_unit u_exec (
    .clk, .rst_n, .run, .pc, .instr, .fetch_done, .mem_done, .load_data,
    .fetch_start, .pc_load, .next_pc, .mem_start, .mem_addr, .mem_wdata, .mem_len,
    .mem_read, .mem_write, .atomic_op, .retire_valid, .retire_pc, .retire_rd,
    .retire_data, .retire_we
  );

  fetch_unit u_fetch (
    .clk, .rst_n, .fetch_start, .pc_load, .next_pc, .fetch_gnt, .ram_rdata,
    .fetch_req, .fetch_addr, .pc, .instr, .fetch_done
  );

  lsu u_lsu (
    .clk, .rst_n, .mem_start, .mem_addr, .mem_wdata, .mem_len, .mem_read, .mem_write,
    .atomic_op, .lsu_gnt, .ram_rdata, .lsu_req, .lsu_we, .lsu_addr, .lsu_be, .lsu_wdata,
    .mem_done, .load_data
  );

  mem_arbiter u_arb (
    .run, .prog_we, .prog_addr, .prog_wdata, .lsu_req, .lsu_we, .lsu_addr, .lsu_be,
    .lsu_wdata, .fetch_req, .fetch_addr, .lsu_gnt, .fetch_gnt, .ram_en, .ram_we,
    .ram_addr, .ram_be, .ram_wdata
  );

  unified_ram u_ram (
    .clk, .ram_en, .ram_we, .ram_addr, .ram_be, .ram_wdata, .ram_rdata
  );

endmodule

// ==== logic/unified_ram.sv ====
`timescale 1ns/1ps

module unified_ram (
  input  logic clk,
  input  logic ram_en,
  input  logic ram_we,
  input  logic [rv_pkg::mem_addr_w-1:0] ram_addr,
  input  logic [3:0] ram_be,
  input  logic [rv_pkg::xlen-1:0] ram_wdata,
  output logic [rv_pkg::xlen-1:0] ram_rdata
);
  import rv_pkg::*;

  logic [xlen-1:0] mem [mem_words];

  always_ff @(posedge clk) begin
    if (ram_en) begin
      if (ram_we) begin
        for (int i = 0; i < 4; i++) begin
          if (ram_be[i]) mem[ram_addr][8*i +: 8] <= ram_wdata[8*i +: 8];
        end
      end else begin
        ram_rdata <= mem[ram_addr]; // One cycle latency.
      end
    end
  end

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
  input  logic run,
  input  logic prog_we,
  input  logic [rv_pkg::mem_addr_w-1:0] prog_addr,
  input  logic [rv_pkg::xlen-1:0] prog_wdata,
  input  logic lsu_req,
  input  logic lsu_we,
  input  logic [rv_pkg::mem_addr_w-1:0] lsu_addr,
  input  logic [3:0] lsu_be,
  input  logic [rv_pkg::xlen-1:0] lsu_wdata,
  input  logic fetch_req,
  input  logic [rv_pkg::mem_addr_w-1:0] fetch_addr,
  output logic lsu_gnt,
  output logic fetch_gnt,
  output logic ram_en,
  output logic ram_we,
  output logic [rv_pkg::mem_addr_w-1:0] ram_addr,
  output logic [3:0] ram_be,
  output logic [rv_pkg::xlen-1:0] ram_wdata
);
  logic prog_sel;

  assign prog_sel = !run && prog_we; // Program loads win while stopped.
  assign lsu_gnt = !prog_sel && lsu_req;
  assign fetch_gnt = !prog_sel && !lsu_req && fetch_req;

  assign ram_en = prog_sel || lsu_req || fetch_req;
  assign ram_we = prog_sel || (lsu_gnt && lsu_we);
  assign ram_addr = prog_sel ? prog_addr : (lsu_gnt ? lsu_addr : fetch_addr);
  assign ram_be = prog_sel ? 4'b1111 : lsu_be;
  assign ram_wdata = prog_sel ? prog_wdata : lsu_wdata;

endmodule

// ==== logic/lsu.sv ====
`timescale 1ns/1ps

module lsu (
  input  logic clk,
  input  logic rst_n,
  input  logic mem_start,
  input  logic [rv_pkg::xlen-1:0] mem_addr,
  input  logic [rv_pkg::xlen-1:0] mem_wdata,
  input  rv_pkg::mem_len_e mem_len,
  input  logic mem_read,
  input  logic mem_write,
  input  rv_pkg::atomic_e atomic_op,
  input  logic lsu_gnt,
  input  logic [rv_pkg::xlen-1:0] ram_rdata,
  output logic lsu_req,
  output logic lsu_we,
  output logic [rv_pkg::mem_addr_w-1:0] lsu_addr,
  output logic [3:0] lsu_be,
  output logic [rv_pkg::xlen-1:0] lsu_wdata,
  output logic mem_done,
  output logic [rv_pkg::xlen-1:0] load_data
);
  import rv_pkg::*;

  typedef enum logic [1:0] {ls_idle, ls_read, ls_wait, ls_write} lsu_state_e;

  lsu_state_e state;
  logic [1:0] off_q;
  mem_len_e len_q;
  atomic_e amo_q;
  logic [xlen-1:0] old_q, shifted;
  logic is_amo;

  assign is_amo = (amo_q != amo_none);
  assign lsu_req = (state == ls_read) || (state == ls_write);
  assign lsu_we = (state == ls_write);
  assign mem_done = (state == ls_wait && !is_amo) || (state == ls_write && lsu_gnt);
  assign shifted = ram_rdata >> {off_q, 3'b000};

  always_comb begin
    if (state != ls_wait) begin
      load_data = old_q;
    end else begin
      case (len_q)
        len_b:   load_data = {{24{shifted[7]}}, shifted[7:0]};
        len_bu:  load_data = {24'd0, shifted[7:0]};
        len_h:   load_data = {{16{shifted[15]}}, shifted[15:0]};
        len_hu:  load_data = {16'd0, shifted[15:0]};
        default: load_data = ram_rdata;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ls_idle;
    end else begin
      case (state)
        ls_idle:  if (mem_start && mem_read) state <= ls_read;
                  else if (mem_start && mem_write) state <= ls_write;
        ls_read:  if (lsu_gnt) state <= ls_wait;
        ls_wait:  state <= is_amo ? ls_write : ls_idle;
        default:  if (lsu_gnt) state <= ls_idle;
      endcase
    end
  end

  // Request fields stay put while the arbiter holds us off.
  always_ff @(posedge clk) begin
    if (state == ls_idle && mem_start) begin
      off_q <= mem_addr[1:0];
      len_q <= mem_len;
      amo_q <= atomic_op;
      lsu_addr <= mem_addr[mem_addr_w+1:2];
      lsu_wdata <= mem_wdata << {mem_addr[1:0], 3'b000};
      case (mem_len)
        len_b, len_bu: lsu_be <= 4'b0001 << mem_addr[1:0];
        len_h, len_hu: lsu_be <= 4'b0011 << mem_addr[1:0];
        default:       lsu_be <= 4'b1111;
      endcase
    end else if (state == ls_wait && is_amo) begin
      old_q <= ram_rdata;
      lsu_wdata <= (amo_q == amo_swap) ? lsu_wdata : ram_rdata + lsu_wdata;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) lsu_req && !lsu_gnt |=> lsu_req)
    else $error("lsu: request dropped before grant");

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
  input  logic clk,
  input  logic rst_n,
  input  logic fetch_start,
  input  logic pc_load,
  input  logic [rv_pkg::xlen-1:0] next_pc,
  input  logic fetch_gnt,
  input  logic [rv_pkg::xlen-1:0] ram_rdata,
  output logic fetch_req,
  output logic [rv_pkg::mem_addr_w-1:0] fetch_addr,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic [rv_pkg::xlen-1:0] instr,
  output logic fetch_done
);
  import rv_pkg::*;

  assign fetch_addr = pc[mem_addr_w+1:2]; // Word address.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= reset_pc;
      fetch_req <= 1'b0;
      fetch_done <= 1'b0;
      instr <= '0;
    end else begin
      if (pc_load) pc <= next_pc;
      if (fetch_start) fetch_req <= 1'b1;
      else if (fetch_gnt) fetch_req <= 1'b0;
      fetch_done <= fetch_req && fetch_gnt; // Read data lands this cycle.
      if (fetch_done) instr <= ram_rdata;
    end
  end

endmodule

// ==== logic/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  input  logic [rv_pkg::xlen-1:0] pc,
  input  logic [rv_pkg::xlen-1:0] instr,
  input  logic fetch_done,
  input  logic mem_done,
  input  logic [rv_pkg::xlen-1:0] load_data,
  output logic fetch_start,
  output logic pc_load,
  output logic [rv_pkg::xlen-1:0] next_pc,
  output logic mem_start,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic [rv_pkg::xlen-1:0] mem_wdata,
  output rv_pkg::mem_len_e mem_len,
  output logic mem_read,
  output logic mem_write,
  output rv_pkg::atomic_e atomic_op,
  output logic retire_valid,
  output logic [rv_pkg::xlen-1:0] retire_pc,
  output logic [4:0] retire_rd,
  output logic [rv_pkg::xlen-1:0] retire_data,
  output logic retire_we
);
  import rv_pkg::*;

  typedef enum logic [2:0] {st_idle, st_fetch, st_exec, st_mem, st_retire} exec_state_e;

  exec_state_e state;
  logic [4:0] rs1, rs2, rd;
  logic [xlen-1:0] immediate;
  logic alu_use_rs2;
  logic reg_write;
  alu_op_e alu_op;
  branch_e branch_type;
  logic [xlen-1:0] regs [32];
  logic [xlen-1:0] rs1_val, rs2_val, alu_b, alu_res, link, target;
  logic [xlen-1:0] result_q, npc_q;
  logic taken;
  logic retire_fire;

  decoder u_decoder (
    .instruction(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .immediate(immediate),
    .alu_use_rs2(alu_use_rs2), .alu_op(alu_op), .reg_write(reg_write),
    .mem_write(mem_write), .mem_read(mem_read), .mem_len(mem_len),
    .branch_type(branch_type), .atomic_op(atomic_op)
  );

  assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1]; // x0 reads zero.
  assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];
  assign alu_b = alu_use_rs2 ? rs2_val : immediate;

  always_comb begin
    case (alu_op)
      alu_sub:  alu_res = rs1_val - alu_b;
      alu_sll:  alu_res = rs1_val << alu_b[4:0];
      alu_slt:  alu_res = {{(xlen-1){1'b0}}, $signed(rs1_val) < $signed(alu_b)};
      alu_sltu: alu_res = {{(xlen-1){1'b0}}, rs1_val < alu_b};
      alu_xor:  alu_res = rs1_val ^ alu_b;
      alu_srl:  alu_res = rs1_val >> alu_b[4:0];
      alu_sra:  alu_res = $signed(rs1_val) >>> alu_b[4:0];
      alu_or:   alu_res = rs1_val | alu_b;
      alu_and:  alu_res = rs1_val & alu_b;
      default:  alu_res = rs1_val + alu_b;
    endcase

    case (branch_type)
      br_eq:   taken = (rs1_val == rs2_val);
      br_ne:   taken = (rs1_val != rs2_val);
      br_lt:   taken = $signed(rs1_val) < $signed(rs2_val);
      br_ge:   taken = $signed(rs1_val) >= $signed(rs2_val);
      br_ltu:  taken = rs1_val < rs2_val;
      br_geu:  taken = rs1_val >= rs2_val;
      br_jal,
      br_jalr: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign link = pc + 32'd4;
  assign target = (branch_type == br_jalr) ? ((rs1_val + immediate) & ~32'd1) : pc + immediate;

  assign retire_fire = (state == st_retire) && run;
  assign fetch_start = (state == st_idle && run) || retire_fire;
  assign pc_load = fetch_start;
  assign next_pc = (state == st_idle) ? reset_pc : npc_q; // Restart from reset_pc.
  assign mem_start = (state == st_exec) && run && (mem_read || mem_write);
  assign mem_addr = alu_res;
  assign mem_wdata = rs2_val;

  assign retire_valid = retire_fire;
  assign retire_pc = pc;
  assign retire_rd = rd;
  assign retire_data = result_q;
  assign retire_we = reg_write;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else if (!run) begin
      state <= st_idle; // Dropping run abandons the instruction.
    end else begin
      case (state)
        st_idle:   state <= st_fetch;
        st_fetch:  if (fetch_done) state <= st_exec;
        st_exec:   state <= mem_start ? st_mem : st_retire;
        st_mem:    if (mem_done) state <= st_retire;
        default:   state <= st_fetch;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_exec) begin
      result_q <= (branch_type == br_jal || branch_type == br_jalr) ? link : alu_res;
      npc_q <= taken ? target : link;
    end else if (state == st_mem && mem_done && mem_read) begin
      result_q <= load_data; // Old word for atomics.
    end
    if (retire_fire && reg_write && rd != 5'd0) begin
      regs[rd] <= result_q;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) retire_valid |=> !retire_valid)
    else $error("exec_unit: retire_valid held for two cycles");

endmodule

// ==== logic/decoder.sv ====
`timescale 1ns/1ps

module decoder (
  input  logic [31:0] instruction,
  output logic [4:0] rs1,
  output logic [4:0] rs2,
  output logic [4:0] rd,
  output logic [31:0] immediate,
  output logic alu_use_rs2,
  output rv_pkg::alu_op_e alu_op,
  output logic reg_write,
  output logic mem_write,
  output logic mem_read,
  output rv_pkg::mem_len_e mem_len,
  output rv_pkg::branch_e branch_type,
  output rv_pkg::atomic_e atomic_op
);
  import rv_pkg::*;

  opcode_e opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic legal;

  assign opcode = opcode_e'(instruction[6:0]);
  assign funct3 = instruction[14:12];
  assign funct7 = instruction[31:25];

  assign rs1 = instruction[19:15];
  assign rs2 = instruction[24:20];
  assign rd = instruction[11:7];
  assign mem_len = mem_len_e'(funct3);
  assign alu_use_rs2 = (opcode == op_reg);

  always_comb begin
    case (opcode)
      op_load:   legal = (funct3 != 3'd3) && (funct3 < 3'd6);
      op_store:  legal = (funct3 < 3'd3);
      op_reg:    legal = (funct7 == 7'd0) ||
                         (funct7 == 7'b0100000 && (funct3 == 3'd0 || funct3 == 3'd5));
      op_imm:    legal = 1'b1;
      op_atomic: legal = (funct3 == 3'd2) &&
                         (instruction[31:27] == amo_add || instruction[31:27] == amo_swap);
      op_branch: legal = (funct3 != 3'd2) && (funct3 != 3'd3);
      op_jal:    legal = 1'b1;
      op_jalr:   legal = (funct3 == 3'd0);
      default:   legal = 1'b0; // Retires as a no-op.
    endcase
  end

  assign reg_write = legal && (opcode == op_load || opcode == op_reg || opcode == op_imm ||
                               opcode == op_atomic || opcode == op_jal || opcode == op_jalr);
  assign mem_read = legal && (opcode == op_load || opcode == op_atomic);
  assign mem_write = legal && (opcode == op_store || opcode == op_atomic);

  always_comb begin
    if (opcode == op_load || opcode == op_store || opcode == op_atomic) begin
      alu_op = alu_add; // Address generation.
    end else if (opcode == op_imm && funct3 != 3'b101) begin
      alu_op = alu_op_e'({2'b00, funct3});
    end else begin
      alu_op = alu_op_e'({instruction[25], instruction[30], funct3});
    end

    case (opcode)
      op_imm:    immediate = (funct3 == 3'b101) ? {27'd0, instruction[24:20]} :
                             {{20{instruction[31]}}, instruction[31:20]};
      op_store:  immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
      op_branch: immediate = {{19{instruction[31]}}, instruction[31], instruction[7],
                              instruction[30:25], instruction[11:8], 1'b0};
      op_jal:    immediate = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                              instruction[20], instruction[30:21], 1'b0};
      op_atomic: immediate = '0;
      default:   immediate = {{20{instruction[31]}}, instruction[31:20]};
    endcase

    if (!legal) branch_type = br_none;
    else if (opcode == op_branch) branch_type = branch_e'({1'b0, funct3});
    else if (opcode == op_jal) branch_type = br_jal;
    else if (opcode == op_jalr) branch_type = br_jalr;
    else branch_type = br_none;

    atomic_op = (legal && opcode == op_atomic) ? atomic_e'(instruction[31:27]) : amo_none;
  end

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen = 32;
  localparam int mem_addr_w = 10;
  localparam int mem_words = 1 << mem_addr_w; // 4 KiB of words.
  localparam logic [xlen-1:0] reset_pc = '0;

  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_atomic = 7'b0101111,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111
  } opcode_e;

  // Layout is {instr[25], instr[30], funct3}.
  typedef enum logic [4:0] {
    alu_add  = 5'b00000,
    alu_sll  = 5'b00001,
    alu_slt  = 5'b00010,
    alu_sltu = 5'b00011,
    alu_xor  = 5'b00100,
    alu_srl  = 5'b00101,
    alu_or   = 5'b00110,
    alu_and  = 5'b00111,
    alu_sub  = 5'b01000,
    alu_sra  = 5'b01101
  } alu_op_e;

  typedef enum logic [3:0] {
    br_eq   = 4'd0,
    br_ne   = 4'd1,
    br_lt   = 4'd4,
    br_ge   = 4'd5,
    br_ltu  = 4'd6,
    br_geu  = 4'd7,
    br_jal  = 4'd8,
    br_jalr = 4'd9,
    br_none = 4'd15
  } branch_e;

  typedef enum logic [4:0] {
    amo_add  = 5'b00000,
    amo_swap = 5'b00001,
    amo_none = 5'b11111 // Unused funct5.
  } atomic_e;

  typedef enum logic [2:0] {
    len_b  = 3'b000,
    len_h  = 3'b001,
    len_w  = 3'b010,
    len_bu = 3'b100,
    len_hu = 3'b101
  } mem_len_e;

endpackage
